/* Bender.yml */
package:
  name: issue_scheduler

sources:
  - target: rtl
    files:
      - hdl/sched_types_pkg.sv
      - hdl/sched_cfg_pkg.sv
      - hdl/issue_bus_if.sv
      - hdl/issue_ctrl.sv
      - hdl/pipe_unit_tracker.sv
      - hdl/seq_unit_tracker.sv
      - hdl/scheduler_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_scheduler.sv

/* bench/sched_model.svh */
// Issue scheduler reference model
// Keeps the work in flight of each unit as a countdown to writeback
// and applies the RAW, writeback collision and busy unit rules
// Included inside the testbench module

`ifndef SCHED_MODEL_SVH
`define SCHED_MODEL_SVH

// ==============================
// Execution stage timing
// ==============================

localparam int REF_BYPASS  = 1;
localparam int REF_ALU_LAT = 1;
localparam int REF_MUL_LAT = 6;
localparam int REF_DIV_LAT = 36;
localparam int REF_LDU_LAT = 3;
localparam int REF_STU_LAT = 2;
// Requested latency with no unit, out of reach of any countdown
localparam int REF_NO_UNIT = 63;

// Multiplier slots, filled in turn
int         mul_left [REF_MUL_LAT];
logic [4:0] mul_rd   [REF_MUL_LAT];
int         mul_next;

// Sequential units, index 0 DIV, 1 LDU, 2 STU
int         seq_left [3];
logic [4:0] seq_rd   [3];

function automatic int seq_latency(input int idx);
    case (idx)
        0:       return REF_DIV_LAT;
        1:       return REF_LDU_LAT;
        default: return REF_STU_LAT;
    endcase
endfunction

function automatic int requested_latency(input logic a, c, m, dv, l, s);
    if (m) return REF_MUL_LAT + REF_BYPASS;
    if (dv) return REF_DIV_LAT + REF_BYPASS;
    if (a || c) return REF_ALU_LAT + REF_BYPASS;
    if (l) return REF_LDU_LAT + REF_BYPASS;
    if (s) return REF_STU_LAT + REF_BYPASS;
    return REF_NO_UNIT;
endfunction

// Pending write to rd that the candidate reads or overwrites, x0 exempt
function automatic logic depends_on(input logic [4:0] rd, s0, s1, d);
    return (rd != 5'd0) && (rd == s0 || rd == s1 || rd == d);
endfunction

function automatic logic expected_issue(input logic [4:0] s0, s1, d,
                                        input logic a, c, m, dv, l, s);
    int         req;
    int         i;
    logic       hold;
    logic [2:0] want;
    req  = requested_latency(a, c, m, dv, l, s);
    want = {s, l, dv};
    hold = 1'b0;
    for (i = 0; i < REF_MUL_LAT; i++) begin
        if (mul_left[i] > 0 && (depends_on(mul_rd[i], s0, s1, d) || mul_left[i] == req)) begin
            hold = 1'b1;
        end
    end
    // A busy sequential unit also refuses a second operation
    for (i = 0; i < 3; i++) begin
        if (seq_left[i] > 0 &&
            (depends_on(seq_rd[i], s0, s1, d) || seq_left[i] == req || want[i])) begin
            hold = 1'b1;
        end
    end
    return !hold;
endfunction

function automatic logic expected_empty();
    int i;
    for (i = 0; i < REF_MUL_LAT; i++) begin
        if (mul_left[i] > 0) return 1'b0;
    end
    for (i = 0; i < 3; i++) begin
        if (seq_left[i] > 0) return 1'b0;
    end
    return 1'b1;
endfunction

task automatic clear_model();
    int i;
    for (i = 0; i < REF_MUL_LAT; i++) begin
        mul_left[i] = 0;
    end
    for (i = 0; i < 3; i++) begin
        seq_left[i] = 0;
    end
    mul_next = 0;
endtask

// One rising edge, fire already excludes stalled cycles
task automatic advance_model(input logic fl, st, fire, m, dv, l, s, input logic [4:0] d);
    int         i;
    logic [2:0] load;
    load = {s, l, dv} & {3{fire}};
    if (fl) begin
        clear_model();
    end else if (!st) begin
        for (i = 0; i < REF_MUL_LAT; i++) begin
            if (fire && m && i == mul_next) begin
                mul_left[i] = REF_MUL_LAT;
                mul_rd[i]   = d;
            end else if (mul_left[i] > 0) begin
                mul_left[i]--;
            end
        end
        if (fire && m) begin
            mul_next = (mul_next + 1) % REF_MUL_LAT;
        end
        for (i = 0; i < 3; i++) begin
            if (load[i]) begin
                seq_left[i] = seq_latency(i);
                seq_rd[i]   = d;
            end else if (seq_left[i] > 0) begin
                seq_left[i]--;
            end
        end
    end
endtask

`endif

/* bench/tb_scheduler.sv */
// Testbench for the issue scheduler
// Directed hazard scenarios, then a random run with stall and flush,
// every cycle compared against the reference model

`timescale 1ns/1ps

module tb_scheduler;

    localparam int DIRECTED_CYCLES = 200;
    localparam int RANDOM_CYCLES   = 2000;
    // Run length plus margin
    localparam int TIMEOUT_CYCLES  = DIRECTED_CYCLES + RANDOM_CYCLES + 800;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        stall;
    logic [4:0]  src0_reg;
    logic [4:0]  src1_reg;
    logic [4:0]  dest_reg;
    logic        alu;
    logic        csr;
    logic        mul;
    logic        div;
    logic        ldu;
    logic        stu;
    logic        issue;
    logic        pipeline_empty;

    // Outputs sampled in the current cycle
    logic        obs_issue;
    logic        obs_empty;
    logic [31:0] lfsr;
    int          cycles;
    int          checks;
    int          errors;
    int          other_errors;

    `include "sched_model.svh"

    scheduler_top dut0 (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .flush_i          (flush),
        .stall_i          (stall),
        .src0_reg_i       (src0_reg),
        .src1_reg_i       (src1_reg),
        .dest_reg_i       (dest_reg),
        .alu_i            (alu),
        .csr_i            (csr),
        .mul_i            (mul),
        .div_i            (div),
        .ldu_i            (ldu),
        .stu_i            (stu),
        .issue_o          (issue),
        .pipeline_empty_o (pipeline_empty)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles without finishing", cycles);
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, errors, other_errors);
        $display("TESTS FAILED");
        $finish;
    end

    // ==============================
    // Stimulus helpers
    // ==============================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic idle_inputs();
        flush    = 1'b0;
        stall    = 1'b0;
        src0_reg = 5'd0;
        src1_reg = 5'd0;
        dest_reg = 5'd0;
        alu      = 1'b0;
        csr      = 1'b0;
        mul      = 1'b0;
        div      = 1'b0;
        ldu      = 1'b0;
        stu      = 1'b0;
    endtask

    // Check the cycle driven at the falling edge, then take the rising edge
    task automatic tick();
        logic exp_issue;
        logic exp_empty;
        #1;
        obs_issue = issue;
        obs_empty = pipeline_empty;
        exp_issue = expected_issue(src0_reg, src1_reg, dest_reg, alu, csr, mul, div, ldu, stu);
        exp_empty = expected_empty();
        checks++;
        if (obs_issue !== exp_issue) begin
            errors++;
            $display("ERR issue_o got %h expected %h at time %0t", obs_issue, exp_issue, $time);
        end
        if (obs_empty !== exp_empty) begin
            errors++;
            $display("ERR pipeline_empty_o got %h expected %h at time %0t",
                     obs_empty, exp_empty, $time);
        end
        @(posedge clk);
        advance_model(flush, stall, exp_issue & ~stall, mul, div, ldu, stu, dest_reg);
        @(negedge clk);
    endtask

    // Hold the request and count cycles until it issues
    task automatic count_blocked(input int limit, output int n);
        n = 0;
        tick();
        while (!obs_issue && n < limit) begin
            n++;
            tick();
        end
        if (!obs_issue) begin
            other_errors++;
            $display("Request was never issued within %0d cycles", limit);
        end
    endtask

    task automatic flush_pipeline();
        idle_inputs();
        flush = 1'b1;
        tick();
        flush = 1'b0;
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        int          i;
        int          n;
        logic [31:0] r;
        lfsr         = 32'h1afe;
        checks       = 0;
        errors       = 0;
        other_errors = 0;
        rst_n        = 1'b0;
        idle_inputs();
        clear_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Empty and free after reset
        tick();
        if (obs_empty !== 1'b1) begin
            errors++;
            $display("ERR pipeline_empty_o after reset got %h expected %h", obs_empty, 1'b1);
        end
        if (obs_issue !== 1'b1) begin
            errors++;
            $display("ERR issue_o after reset got %h expected %h", obs_issue, 1'b1);
        end

        // DIV to x5, then an ALU op reading x5
        div      = 1'b1;
        dest_reg = 5'd5;
        src0_reg = 5'd1;
        src1_reg = 5'd2;
        tick();
        idle_inputs();
        alu      = 1'b1;
        src0_reg = 5'd5;
        dest_reg = 5'd6;
        count_blocked(REF_DIV_LAT + 8, n);
        if (n != REF_DIV_LAT) begin
            errors++;
            $display("ERR issue_o RAW blocked cycles got %h expected %h", n, REF_DIV_LAT);
        end

        // Second DIV waits for the busy divider
        idle_inputs();
        div      = 1'b1;
        dest_reg = 5'd5;
        tick();
        src0_reg = 5'd1;
        src1_reg = 5'd2;
        dest_reg = 5'd3;
        count_blocked(REF_DIV_LAT + 8, n);
        if (n != REF_DIV_LAT) begin
            errors++;
            $display("ERR issue_o structural blocked cycles got %h expected %h",
                     n, REF_DIV_LAT);
        end
        flush_pipeline();

        // Six MULs back to back fill every slot
        for (i = 1; i <= REF_MUL_LAT; i++) begin
            idle_inputs();
            mul      = 1'b1;
            dest_reg = 5'(i);
            tick();
            if (obs_issue !== 1'b1) begin
                errors++;
                $display("ERR issue_o MUL %0d got %h expected %h", i, obs_issue, 1'b1);
            end
        end
        // ALU result would land together with a live MUL
        idle_inputs();
        alu      = 1'b1;
        src0_reg = 5'd7;
        src1_reg = 5'd7;
        dest_reg = 5'd7;
        tick();
        if (obs_issue !== 1'b0) begin
            errors++;
            $display("ERR issue_o writeback collision got %h expected %h", obs_issue, 1'b0);
        end
        idle_inputs();
        n = 0;
        tick();
        while (!obs_empty && n < 20) begin
            n++;
            tick();
        end
        // Last MUL has one edge behind it already
        if (n != REF_MUL_LAT - 1) begin
            errors++;
            $display("ERR pipeline_empty_o busy cycles got %h expected %h", n, REF_MUL_LAT - 1);
        end

        // Stall stretches the DIV window by its length
        div      = 1'b1;
        dest_reg = 5'd5;
        tick();
        idle_inputs();
        alu      = 1'b1;
        src0_reg = 5'd5;
        dest_reg = 5'd6;
        n        = 0;
        for (i = 0; i < REF_DIV_LAT + 30; i++) begin
            stall = (i >= 5) && (i < 15);
            tick();
            if (obs_issue) break;
            n++;
        end
        if (n != REF_DIV_LAT + 10) begin
            errors++;
            $display("ERR issue_o stalled blocked cycles got %h expected %h",
                     n, REF_DIV_LAT + 10);
        end

        // Flush empties DIV and MUL at once
        idle_inputs();
        div      = 1'b1;
        dest_reg = 5'd5;
        tick();
        idle_inputs();
        mul      = 1'b1;
        dest_reg = 5'd4;
        tick();
        flush_pipeline();
        tick();
        if (obs_empty !== 1'b1) begin
            errors++;
            $display("ERR pipeline_empty_o after flush got %h expected %h", obs_empty, 1'b1);
        end

        // Writes to x0 never block a reader of x0
        div = 1'b1;
        tick();
        idle_inputs();
        mul = 1'b1;
        tick();
        idle_inputs();
        alu = 1'b1;
        tick();
        if (obs_issue !== 1'b1) begin
            errors++;
            $display("ERR issue_o with x0 in flight got %h expected %h", obs_issue, 1'b1);
        end
        flush_pipeline();

        // ==============================
        // Random run
        // ==============================

        for (i = 0; i < RANDOM_CYCLES; i++) begin
            idle_inputs();
            draw_bits(3, r);
            src0_reg = r[4:0];
            draw_bits(3, r);
            src1_reg = r[4:0];
            draw_bits(3, r);
            dest_reg = r[4:0];
            draw_bits(3, r);
            case (r[2:0])
                3'd1:    alu = 1'b1;
                3'd2:    csr = 1'b1;
                3'd3:    mul = 1'b1;
                3'd4:    div = 1'b1;
                3'd5:    ldu = 1'b1;
                3'd6:    stu = 1'b1;
                default: ;
            endcase
            draw_bits(4, r);
            stall = (r[3:0] == 4'd0);
            draw_bits(6, r);
            flush = (r[5:0] == 6'd0);
            tick();
        end
        idle_inputs();

        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, errors, other_errors);
        if (errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_scheduler

/* hdl/issue_bus_if.sv */
// Issue bus
// Broadcasts the candidate instruction, its requested latency and the
// issue, stall and flush strobes from the controller to every tracker

`timescale 1ns/1ps

interface issue_bus_if import sched_types_pkg::*; ();

    // Candidate instruction registers
    reg_idx_t src0;
    reg_idx_t src1;
    reg_idx_t dest;

    // Cycles to writeback, bypass stage included
    lat_cnt_t req_lat;

    // Issue on this edge, already qualified with stall
    logic     fire;

    // Freeze and clear strobes for tracker state
    logic     stall;
    logic     flush;

    // Controller side drives everything
    modport ctrl (
        output src0, src1, dest, req_lat, fire, stall, flush
    );

    // Trackers only listen
    modport tracker (
        input  src0, src1, dest, req_lat, fire, stall, flush
    );

endinterface : issue_bus_if

/* hdl/issue_ctrl.sv */
// Issue controller
// Selects the requested latency of the waiting instruction, merges the
// RAW, writeback collision and structural hazards of all trackers and
// drives the issue and pipeline empty flags
// Tracker index order is MUL, DIV, LDU, STU

`timescale 1ns/1ps

module issue_ctrl import sched_types_pkg::*, sched_cfg_pkg::*; (
    input  logic     flush_i,
    input  logic     stall_i,

    // Candidate instruction
    input  reg_idx_t src0_reg_i,
    input  reg_idx_t src1_reg_i,
    input  reg_idx_t dest_reg_i,

    // Unit selects
    input  logic     alu_i,
    input  logic     csr_i,
    input  logic     mul_i,
    input  logic     div_i,
    input  logic     ldu_i,
    input  logic     stu_i,

    // Tracker status
    input  logic [3:0] raw_hz_i,
    input  logic [3:0] lat_hz_i,
    input  logic [3:0] busy_i,

    issue_bus_if.ctrl bus,

    output logic     issue_o,
    output logic     pipeline_empty_o
);

    // ==============================
    // Requested latency
    // ==============================

    lat_cnt_t req_lat;

    // Priority order follows the unit decode
    always_comb begin
        if (mul_i) begin
            req_lat = lat_cnt_t'(MUL_LATENCY + BYPASS_STAGES);
        end else if (div_i) begin
            req_lat = lat_cnt_t'(DIV_LATENCY + BYPASS_STAGES);
        end else if (alu_i | csr_i) begin
            req_lat = lat_cnt_t'(ALU_LATENCY + BYPASS_STAGES);
        end else if (ldu_i) begin
            req_lat = lat_cnt_t'(LDU_LATENCY + BYPASS_STAGES);
        end else if (stu_i) begin
            req_lat = lat_cnt_t'(STU_LATENCY + BYPASS_STAGES);
        end else begin
            req_lat = lat_cnt_t'(NO_UNIT_LATENCY);
        end
    end

    // ==============================
    // Hazards and issue
    // ==============================

    logic raw_hz;
    logic lat_hz;
    logic struct_hz;

    assign raw_hz = |raw_hz_i;
    assign lat_hz = |lat_hz_i;

    // Non pipelined units accept one operation at a time
    assign struct_hz = (div_i & busy_i[1]) | (ldu_i & busy_i[2]) | (stu_i & busy_i[3]);

    assign issue_o          = ~(raw_hz | lat_hz | struct_hz);
    assign pipeline_empty_o = ~(|busy_i);

    // Broadcast to trackers
    assign bus.src0    = src0_reg_i;
    assign bus.src1    = src1_reg_i;
    assign bus.dest    = dest_reg_i;
    assign bus.req_lat = req_lat;
    // Stalled issues do not load any tracker
    assign bus.fire    = issue_o & ~stall_i;
    assign bus.stall   = stall_i;
    assign bus.flush   = flush_i;

endmodule : issue_ctrl

/* hdl/pipe_unit_tracker.sv */
// Pipelined unit tracker
// One latency counter and destination per unit stage, filled in turn
// by a rotating one-hot slot pointer that moves on every unit issue
// Reports RAW hazard, writeback collision and busy over all slots

`timescale 1ns/1ps

module pipe_unit_tracker import sched_types_pkg::*; #(
    parameter int unsigned STAGES  = 6,
    parameter int unsigned LATENCY = 6
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic sel_i,

    issue_bus_if.tracker bus,

    output logic raw_hz_o,
    output logic lat_hz_o,
    output logic busy_o
);

    // Unit issue on this edge
    logic load;

    assign load = bus.fire & sel_i;

    // ==============================
    // Slot pointer
    // ==============================

    logic [STAGES-1:0] slot_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            slot_q <= STAGES'(1);
        end else if (bus.flush) begin
            slot_q <= STAGES'(1);
        end else if (load) begin
            // Rotate left, top slot wraps to slot 0
            slot_q <= {slot_q[STAGES-2:0], slot_q[STAGES-1]};
        end
    end

    // ==============================
    // Per slot state
    // ==============================

    lat_cnt_t          cnt_q  [STAGES];
    reg_idx_t          dest_q [STAGES];
    logic [STAGES-1:0] slot_busy;
    logic [STAGES-1:0] slot_raw;
    logic [STAGES-1:0] slot_lat;

    for (genvar s = 0; s < STAGES; s++) begin : g_slot

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                cnt_q[s] <= '0;
            end else if (bus.flush) begin
                cnt_q[s] <= '0;
            end else if (!bus.stall) begin
                if (load & slot_q[s]) begin
                    cnt_q[s] <= lat_cnt_t'(LATENCY);
                end else if (cnt_q[s] != '0) begin
                    // Count down towards writeback
                    cnt_q[s] <= cnt_q[s] - lat_cnt_t'(1);
                end
            end
        end

        // Destination only matters while the slot is busy
        always_ff @(posedge clk_i) begin
            if (load & slot_q[s]) begin
                dest_q[s] <= bus.dest;
            end
        end

        assign slot_busy[s] = (cnt_q[s] != '0);

        // x0 is never a real dependency
        assign slot_raw[s] = slot_busy[s] & (dest_q[s] != '0) &
                             ((dest_q[s] == bus.src0) | (dest_q[s] == bus.src1) |
                              (dest_q[s] == bus.dest));

        // Same writeback cycle as the new instruction
        assign slot_lat[s] = slot_busy[s] & (cnt_q[s] == bus.req_lat);

    end

    assign raw_hz_o = |slot_raw;
    assign lat_hz_o = |slot_lat;
    assign busy_o   = |slot_busy;

endmodule : pipe_unit_tracker

/* hdl/sched_cfg_pkg.sv */
// Scheduler configuration
// Functional unit latencies and pipeline depth of the execution stage
// Requested latencies add the bypass stage in front of execute

package sched_cfg_pkg;

    // Stage between issue and execute
    localparam int unsigned BYPASS_STAGES = 1;

    // ALU and CSR produce a result in one cycle
    localparam int unsigned ALU_LATENCY = 1;

    // Multiplier latency, also the number of tracked stages
    localparam int unsigned MUL_LATENCY = 6;

    // Iterative divider
    localparam int unsigned DIV_LATENCY = 36;

    // Load and store units
    localparam int unsigned LDU_LATENCY = 3;
    localparam int unsigned STU_LATENCY = 2;

    // All ones in the counter width
    // A live counter never reaches this value
    localparam int unsigned NO_UNIT_LATENCY = (1 << sched_types_pkg::LAT_CNT_W) - 1;

endpackage : sched_cfg_pkg

/* hdl/sched_types_pkg.sv */
// Scheduler types
// Register index and latency counter widths shared by the issue
// controller, the issue bus and the unit trackers

package sched_types_pkg;

    // Architectural register address, x0 to x31
    localparam int unsigned REG_IDX_W = 5;

    // Wide enough to hold the divider latency plus the bypass stage
    localparam int unsigned LAT_CNT_W = 6;

    // ==============================
    // Typedefs
    // ==============================

    // Register address
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Cycles left until writeback
    typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

endpackage : sched_types_pkg

/* hdl/scheduler_top.sv */
// Issue scheduler
// Holds back the instruction waiting to issue while it has a RAW
// hazard, a writeback collision or a busy non-pipelined unit
// One pipelined tracker for MUL and sequential trackers for DIV, LDU, STU

`timescale 1ns/1ps

module scheduler_top import sched_types_pkg::*, sched_cfg_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     stall_i,

    // Register addresses of the waiting instruction
    input  reg_idx_t src0_reg_i,
    input  reg_idx_t src1_reg_i,
    input  reg_idx_t dest_reg_i,

    // Functional unit select, at most one high
    input  logic     alu_i,
    input  logic     csr_i,
    input  logic     mul_i,
    input  logic     div_i,
    input  logic     ldu_i,
    input  logic     stu_i,

    output logic     issue_o,
    output logic     pipeline_empty_o
);

    // Tracker status, index 0 MUL, 1 DIV, 2 LDU, 3 STU
    logic [3:0] raw_hz;
    logic [3:0] lat_hz;
    logic [3:0] busy;

    issue_bus_if bus ();

    // ==============================
    // Controller
    // ==============================

    issue_ctrl u_ctrl (
        .flush_i          (flush_i),
        .stall_i          (stall_i),
        .src0_reg_i       (src0_reg_i),
        .src1_reg_i       (src1_reg_i),
        .dest_reg_i       (dest_reg_i),
        .alu_i            (alu_i),
        .csr_i            (csr_i),
        .mul_i            (mul_i),
        .div_i            (div_i),
        .ldu_i            (ldu_i),
        .stu_i            (stu_i),
        .raw_hz_i         (raw_hz),
        .lat_hz_i         (lat_hz),
        .busy_i           (busy),
        .bus              (bus.ctrl),
        .issue_o          (issue_o),
        .pipeline_empty_o (pipeline_empty_o)
    );

    // ==============================
    // Unit trackers
    // ==============================

    // One slot per multiplier stage
    pipe_unit_tracker #(
        .STAGES  (MUL_LATENCY),
        .LATENCY (MUL_LATENCY)
    ) mul_trk (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .sel_i    (mul_i),
        .bus      (bus.tracker),
        .raw_hz_o (raw_hz[0]),
        .lat_hz_o (lat_hz[0]),
        .busy_o   (busy[0])
    );

    seq_unit_tracker #(
        .LATENCY (DIV_LATENCY)
    ) div_trk (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .sel_i    (div_i),
        .bus      (bus.tracker),
        .raw_hz_o (raw_hz[1]),
        .lat_hz_o (lat_hz[1]),
        .busy_o   (busy[1])
    );

    seq_unit_tracker #(
        .LATENCY (LDU_LATENCY)
    ) ldu_trk (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .sel_i    (ldu_i),
        .bus      (bus.tracker),
        .raw_hz_o (raw_hz[2]),
        .lat_hz_o (lat_hz[2]),
        .busy_o   (busy[2])
    );

    seq_unit_tracker #(
        .LATENCY (STU_LATENCY)
    ) stu_trk (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .sel_i    (stu_i),
        .bus      (bus.tracker),
        .raw_hz_o (raw_hz[3]),
        .lat_hz_o (lat_hz[3]),
        .busy_o   (busy[3])
    );

endmodule : scheduler_top

/* hdl/seq_unit_tracker.sv */
// Sequential unit tracker
// Single latency counter and destination for a unit that holds one
// operation at a time, used for the divider, loads and stores

`timescale 1ns/1ps

module seq_unit_tracker import sched_types_pkg::*; #(
    parameter int unsigned LATENCY = 36
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic sel_i,

    issue_bus_if.tracker bus,

    output logic raw_hz_o,
    output logic lat_hz_o,
    output logic busy_o
);

    lat_cnt_t cnt_q;
    reg_idx_t dest_q;
    logic     load;

    // Unit issue on this edge
    assign load = bus.fire & sel_i;

    // ==============================
    // Latency counter
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (bus.flush) begin
            cnt_q <= '0;
        end else if (!bus.stall) begin
            if (load) begin
                cnt_q <= lat_cnt_t'(LATENCY);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - lat_cnt_t'(1);
            end
        end
    end

    // Destination of the operation in flight
    always_ff @(posedge clk_i) begin
        if (load) begin
            dest_q <= bus.dest;
        end
    end

    assign busy_o = (cnt_q != '0);

    // Writes to x0 are discarded, so no dependency
    assign raw_hz_o = busy_o & (dest_q != '0) &
                      ((dest_q == bus.src0) | (dest_q == bus.src1) | (dest_q == bus.dest));

    assign lat_hz_o = busy_o & (cnt_q == bus.req_lat);

endmodule : seq_unit_tracker

/* vlog.f */
+incdir+bench
hdl/sched_types_pkg.sv
hdl/sched_cfg_pkg.sv
hdl/issue_bus_if.sv
hdl/issue_ctrl.sv
hdl/pipe_unit_tracker.sv
hdl/seq_unit_tracker.sv
hdl/scheduler_top.sv
bench/tb_scheduler.sv
